// ==== build.f ====
getir_pkg.sv
dallanma_ongorucu.sv
ps_uretici.sv
buyruk_kuyrugu.sv
getir.sv
tb_bellek_model.sv
tb_getir.sv

// ==== buyruk_kuyrugu.sv ====
module buyruk_kuyrugu (
    input  logic                    clk_i,
    input  logic                    rst_n_i,

    // Request side
    input  logic                    istek_kabul_i,
    input  getir_pkg::ps_t          ps_i,
    input  getir_pkg::tahmin_t      tahmin_i,
    input  logic                    bosalt_i,

    // Memory response
    input  getir_pkg::buyruk_t      yanit_veri_i,
    input  logic                    yanit_gecerli_i,

    // Decode side
    input  logic                    coz_hazir_i,
    output logic                    yer_var_o,
    output getir_pkg::getir_cikis_t coz_cikis_o,
    output logic                    coz_gecerli_o
);

    getir_pkg::getir_cikis_t kayit_q [getir_pkg::KUYRUK_DERINLIK];
    logic [getir_pkg::KUYRUK_DERINLIK-1:0] dolu_q;

    getir_pkg::kuyruk_isaret_t yaz_isaret_q;
    getir_pkg::kuyruk_isaret_t yanit_isaret_q;
    getir_pkg::kuyruk_isaret_t oku_isaret_q;

    // Reserved entries, entries still waiting for data, and stale responses owed
    getir_pkg::kuyruk_sayi_t   sayi_q;
    getir_pkg::kuyruk_sayi_t   bekleyen_q;
    getir_pkg::kuyruk_sayi_t   borc_q;

    logic [getir_pkg::KUYRUK_SAYI_BIT:0] toplam;
    logic                                yanit_al;
    logic                                yanit_at;
    logic                                cikis;

    // Owed responses still occupy the memory pipe
    assign toplam    = {1'b0, sayi_q} + {1'b0, borc_q};
    assign yer_var_o = toplam < getir_pkg::KUYRUK_DERINLIK;

    assign yanit_al = yanit_gecerli_i && (borc_q == '0);
    assign yanit_at = yanit_gecerli_i && (borc_q != '0);

    assign coz_gecerli_o = dolu_q[oku_isaret_q];
    assign coz_cikis_o   = kayit_q[oku_isaret_q];
    assign cikis         = coz_gecerli_o && coz_hazir_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            yaz_isaret_q   <= '0;
            yanit_isaret_q <= '0;
            oku_isaret_q   <= '0;
            sayi_q         <= '0;
            bekleyen_q     <= '0;
            borc_q         <= '0;
            dolu_q         <= '0;
        end else if (bosalt_i) begin
            yaz_isaret_q   <= '0;
            yanit_isaret_q <= '0;
            oku_isaret_q   <= '0;
            sayi_q         <= '0;
            bekleyen_q     <= '0;
            dolu_q         <= '0;
            // A response in this cycle pays off one of the outstanding fetches
            borc_q <= borc_q + bekleyen_q - getir_pkg::kuyruk_sayi_t'(yanit_gecerli_i);
        end else begin
            if (yanit_at) begin
                borc_q <= borc_q - 1'b1;
            end
            if (istek_kabul_i) begin
                yaz_isaret_q <= yaz_isaret_q + 1'b1;
            end
            if (yanit_al) begin
                dolu_q[yanit_isaret_q] <= 1'b1;
                yanit_isaret_q         <= yanit_isaret_q + 1'b1;
            end
            if (cikis) begin
                dolu_q[oku_isaret_q] <= 1'b0;
                oku_isaret_q         <= oku_isaret_q + 1'b1;
            end
            sayi_q <= sayi_q + getir_pkg::kuyruk_sayi_t'(istek_kabul_i)
                             - getir_pkg::kuyruk_sayi_t'(cikis);
            bekleyen_q <= bekleyen_q + getir_pkg::kuyruk_sayi_t'(istek_kabul_i)
                                     - getir_pkg::kuyruk_sayi_t'(yanit_al);
        end
    end

    // PC and prediction at acceptance, instruction word at response
    always_ff @(posedge clk_i) begin
        if (istek_kabul_i) begin
            kayit_q[yaz_isaret_q].ps     <= ps_i;
            kayit_q[yaz_isaret_q].atladi <= tahmin_i.atladi;
        end
        if (yanit_al) begin
            kayit_q[yanit_isaret_q].buyruk <= yanit_veri_i;
        end
    end

endmodule

// ==== dallanma_ongorucu.sv ====
module dallanma_ongorucu (
    input  logic                   clk_i,
    input  logic                   rst_n_i,

    input  getir_pkg::ps_t         ps_i,
    input  getir_pkg::guncelleme_t guncelleme_i,

    output getir_pkg::tahmin_t     tahmin_o
);

    // Per-entry valid bit, tag, target and counter
    logic [getir_pkg::BTB_SATIR-1:0] gecerli_q;
    getir_pkg::btb_etiket_t          etiket_q [getir_pkg::BTB_SATIR];
    getir_pkg::ps_t                  hedef_q  [getir_pkg::BTB_SATIR];
    getir_pkg::sayac_t               sayac_q  [getir_pkg::BTB_SATIR];

    getir_pkg::btb_indis_t  oku_indis;
    getir_pkg::btb_etiket_t oku_etiket;
    logic                   oku_isabet;

    getir_pkg::btb_indis_t  yaz_indis;
    getir_pkg::btb_etiket_t yaz_etiket;
    logic                   yaz_isabet;
    getir_pkg::sayac_t      yaz_sayac;

    // Lookup with the current fetch PC
    assign oku_indis  = ps_i[getir_pkg::BTB_INDIS_BIT+1:2];
    assign oku_etiket = ps_i[getir_pkg::PS_BIT-1:getir_pkg::BTB_INDIS_BIT+2];
    assign oku_isabet = gecerli_q[oku_indis] && (etiket_q[oku_indis] == oku_etiket);

    // Upper counter bit means counter is 2 or 3
    assign tahmin_o.atladi = oku_isabet && sayac_q[oku_indis][1];
    assign tahmin_o.hedef  = hedef_q[oku_indis];

    assign yaz_indis  = guncelleme_i.ps[getir_pkg::BTB_INDIS_BIT+1:2];
    assign yaz_etiket = guncelleme_i.ps[getir_pkg::PS_BIT-1:getir_pkg::BTB_INDIS_BIT+2];
    assign yaz_isabet = gecerli_q[yaz_indis] && (etiket_q[yaz_indis] == yaz_etiket);

    // Saturating counter step
    always_comb begin
        if (!yaz_isabet) begin
            // New entries start weak
            yaz_sayac = guncelleme_i.atladi ? getir_pkg::SAYAC_ZAYIF_ATLA
                                            : getir_pkg::SAYAC_ZAYIF_ATLAMA;
        end else if (guncelleme_i.atladi) begin
            if (sayac_q[yaz_indis] == getir_pkg::SAYAC_GUCLU_ATLA) begin
                yaz_sayac = getir_pkg::SAYAC_GUCLU_ATLA;
            end else begin
                yaz_sayac = sayac_q[yaz_indis] + 2'd1;
            end
        end else begin
            if (sayac_q[yaz_indis] == getir_pkg::SAYAC_GUCLU_ATLAMA) begin
                yaz_sayac = getir_pkg::SAYAC_GUCLU_ATLAMA;
            end else begin
                yaz_sayac = sayac_q[yaz_indis] - 2'd1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            gecerli_q <= '0;
        end else if (guncelleme_i.gecerli) begin
            gecerli_q[yaz_indis] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (guncelleme_i.gecerli) begin
            etiket_q[yaz_indis] <= yaz_etiket;
            hedef_q[yaz_indis]  <= guncelleme_i.hedef;
            sayac_q[yaz_indis]  <= yaz_sayac;
        end
    end

endmodule

// ==== getir.sv ====
module getir (
    input  logic                    clk_i,
    input  logic                    rst_n_i,

    // Instruction memory
    output getir_pkg::ps_t          buyruk_istek_adres_o,
    output logic                    buyruk_istek_gecerli_o,
    input  logic                    buyruk_istek_hazir_i,
    input  getir_pkg::buyruk_t      buyruk_yanit_veri_i,
    input  logic                    buyruk_yanit_gecerli_i,

    // Execute and trap redirects
    input  getir_pkg::yonlendirme_t yurut_yonlendirme_i,
    input  getir_pkg::guncelleme_t  yurut_guncelleme_i,
    input  getir_pkg::yonlendirme_t ddb_yonlendirme_i,

    // Decode
    output getir_pkg::getir_cikis_t coz_cikis_o,
    output logic                    coz_gecerli_o,
    input  logic                    coz_hazir_i
);

    getir_pkg::ps_t     ps;
    getir_pkg::tahmin_t tahmin;
    logic               istek_kabul;
    logic               bosalt;
    logic               yer_var;

    ps_uretici ps_uretici_i (
        .clk_i               ( clk_i ),
        .rst_n_i             ( rst_n_i ),
        .ddb_yonlendirme_i   ( ddb_yonlendirme_i ),
        .yurut_yonlendirme_i ( yurut_yonlendirme_i ),
        .tahmin_i            ( tahmin ),
        .yer_var_i           ( yer_var ),
        .istek_hazir_i       ( buyruk_istek_hazir_i ),
        .ps_o                ( ps ),
        .istek_gecerli_o     ( buyruk_istek_gecerli_o ),
        .istek_kabul_o       ( istek_kabul ),
        .bosalt_o            ( bosalt )
    );

    // Works on the same PC as the request
    dallanma_ongorucu dallanma_ongorucu_i (
        .clk_i        ( clk_i ),
        .rst_n_i      ( rst_n_i ),
        .ps_i         ( ps ),
        .guncelleme_i ( yurut_guncelleme_i ),
        .tahmin_o     ( tahmin )
    );

    buyruk_kuyrugu buyruk_kuyrugu_i (
        .clk_i           ( clk_i ),
        .rst_n_i         ( rst_n_i ),
        .istek_kabul_i   ( istek_kabul ),
        .ps_i            ( ps ),
        .tahmin_i        ( tahmin ),
        .bosalt_i        ( bosalt ),
        .yanit_veri_i    ( buyruk_yanit_veri_i ),
        .yanit_gecerli_i ( buyruk_yanit_gecerli_i ),
        .coz_hazir_i     ( coz_hazir_i ),
        .yer_var_o       ( yer_var ),
        .coz_cikis_o     ( coz_cikis_o ),
        .coz_gecerli_o   ( coz_gecerli_o )
    );

    assign buyruk_istek_adres_o = ps;

endmodule

// ==== getir_pkg.sv ====
package getir_pkg;

    // Core widths
    localparam int PS_BIT     = 32;
    localparam int BUYRUK_BIT = 32;

    // Branch target buffer geometry, index taken from PC bits 5:2
    localparam int BTB_SATIR      = 16;
    localparam int BTB_INDIS_BIT  = 4;
    localparam int BTB_ETIKET_BIT = PS_BIT - BTB_INDIS_BIT - 2;

    // Fetch queue geometry
    localparam int KUYRUK_DERINLIK   = 4;
    localparam int KUYRUK_ISARET_BIT = $clog2(KUYRUK_DERINLIK);
    localparam int KUYRUK_SAYI_BIT   = $clog2(KUYRUK_DERINLIK + 1);

    typedef logic [PS_BIT-1:0]            ps_t;
    typedef logic [BUYRUK_BIT-1:0]        buyruk_t;
    typedef logic [1:0]                   sayac_t;
    typedef logic [BTB_INDIS_BIT-1:0]     btb_indis_t;
    typedef logic [BTB_ETIKET_BIT-1:0]    btb_etiket_t;
    typedef logic [KUYRUK_ISARET_BIT-1:0] kuyruk_isaret_t;
    typedef logic [KUYRUK_SAYI_BIT-1:0]   kuyruk_sayi_t;

    // Reset vector and sequential step
    localparam ps_t BASLANGIC_PS = 32'h8000_0000;
    localparam ps_t PS_ADIM      = 32'd4;

    // Counter levels
    localparam sayac_t SAYAC_ZAYIF_ATLAMA  = 2'd1;
    localparam sayac_t SAYAC_ZAYIF_ATLA    = 2'd2;
    localparam sayac_t SAYAC_GUCLU_ATLAMA  = 2'd0;
    localparam sayac_t SAYAC_GUCLU_ATLA    = 2'd3;

    // Redirect from trap logic or execute
    typedef struct packed {
        ps_t  ps;
        logic gecerli;
    } yonlendirme_t;

    // Predictor training from execute
    typedef struct packed {
        ps_t  ps;
        ps_t  hedef;
        logic atladi;
        logic gecerli;
    } guncelleme_t;

    typedef struct packed {
        ps_t  hedef;
        logic atladi;
    } tahmin_t;

    // One fetched instruction towards decode
    typedef struct packed {
        buyruk_t buyruk;
        ps_t     ps;
        logic    atladi;
    } getir_cikis_t;

endpackage

// ==== ps_uretici.sv ====
module ps_uretici (
    input  logic                    clk_i,
    input  logic                    rst_n_i,

    input  getir_pkg::yonlendirme_t ddb_yonlendirme_i,
    input  getir_pkg::yonlendirme_t yurut_yonlendirme_i,
    input  getir_pkg::tahmin_t      tahmin_i,
    input  logic                    yer_var_i,
    input  logic                    istek_hazir_i,

    output getir_pkg::ps_t          ps_o,
    output logic                    istek_gecerli_o,
    output logic                    istek_kabul_o,
    output logic                    bosalt_o
);

    getir_pkg::ps_t ps_q;
    getir_pkg::ps_t ps_sonraki;
    logic           calisiyor_q;
    logic           yonlendirme_var;

    assign yonlendirme_var = ddb_yonlendirme_i.gecerli || yurut_yonlendirme_i.gecerli;

    // No request in a redirect cycle, the new PC goes out next cycle
    assign istek_gecerli_o = calisiyor_q && yer_var_i && !yonlendirme_var;
    assign istek_kabul_o   = istek_gecerli_o && istek_hazir_i;
    assign bosalt_o        = yonlendirme_var;
    assign ps_o            = ps_q;

    // Trap, then execute, then prediction, then sequential
    always_comb begin
        ps_sonraki = ps_q;
        if (ddb_yonlendirme_i.gecerli) begin
            ps_sonraki = ddb_yonlendirme_i.ps;
        end else if (yurut_yonlendirme_i.gecerli) begin
            ps_sonraki = yurut_yonlendirme_i.ps;
        end else if (istek_kabul_o) begin
            if (tahmin_i.atladi) begin
                ps_sonraki = tahmin_i.hedef;
            end else begin
                ps_sonraki = ps_q + getir_pkg::PS_ADIM;
            end
        end
    end

    // Held low during reset so the first request follows its release
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            calisiyor_q <= 1'b0;
        end else begin
            calisiyor_q <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ps_q <= getir_pkg::BASLANGIC_PS;
        end else begin
            ps_q <= ps_sonraki;
        end
    end

endmodule

// ==== tb_bellek_model.sv ====
module tb_bellek_model #(
    parameter int                 TOHUM        = 1,
    parameter getir_pkg::buyruk_t VERI_ANAHTAR = '0
) (
    input  logic               clk_i,
    input  logic               rst_n_i,

    input  getir_pkg::ps_t     istek_adres_i,
    input  logic               istek_gecerli_i,
    output logic               istek_hazir_o,

    output getir_pkg::buyruk_t yanit_veri_o,
    output logic               yanit_gecerli_o
);

    integer             seed;
    int unsigned        cevrim;
    getir_pkg::buyruk_t veri_q [$];
    int unsigned        vade_q [$];

    initial begin
        seed            = TOHUM;
        cevrim          = 0;
        istek_hazir_o   = 1'b0;
        yanit_veri_o    = '0;
        yanit_gecerli_o = 1'b0;
    end

    // Accepted requests come due one to three cycles later
    always @(posedge clk_i) begin
        if (!rst_n_i) begin
            cevrim = 0;
            veri_q.delete();
            vade_q.delete();
        end else begin
            cevrim++;
            if (istek_gecerli_i && istek_hazir_o) begin
                veri_q.push_back(istek_adres_i ^ VERI_ANAHTAR);
                vade_q.push_back(cevrim + (($random(seed) & 32'h7fff_ffff) % 3));
            end
        end
    end

    // Outputs change on the falling edge only
    always @(negedge clk_i) begin
        if (!rst_n_i) begin
            istek_hazir_o   = 1'b0;
            yanit_veri_o    = '0;
            yanit_gecerli_o = 1'b0;
        end else begin
            istek_hazir_o = ($random(seed) & 3) != 0;
            if (vade_q.size() > 0 && vade_q[0] <= cevrim) begin
                yanit_veri_o    = veri_q.pop_front();
                yanit_gecerli_o = 1'b1;
                void'(vade_q.pop_front());
            end else begin
                yanit_veri_o    = '0;
                yanit_gecerli_o = 1'b0;
            end
        end
    end

endmodule

// ==== tb_getir.sv ====
module tb_getir;

    localparam int                 TOHUM          = 5104;
    localparam getir_pkg::buyruk_t VERI_ANAHTAR   = 32'h1357_9bdf;
    localparam getir_pkg::ps_t     DALLANMA_PS    = 32'h8000_0040;
    localparam getir_pkg::ps_t     DALLANMA_HEDEF = 32'h8000_0100;
    // About ten times the 300 cycles the tests take
    localparam int                 ZAMAN_ASIMI    = 3000;

    logic                    clk_i;
    logic                    rst_n_i;
    getir_pkg::ps_t          buyruk_istek_adres;
    logic                    buyruk_istek_gecerli;
    logic                    buyruk_istek_hazir;
    getir_pkg::buyruk_t      buyruk_yanit_veri;
    logic                    buyruk_yanit_gecerli;
    getir_pkg::yonlendirme_t yurut_yonlendirme;
    getir_pkg::guncelleme_t  yurut_guncelleme;
    getir_pkg::yonlendirme_t ddb_yonlendirme;
    getir_pkg::getir_cikis_t coz_cikis;
    logic                    coz_gecerli;
    logic                    coz_hazir;

    integer seed;
    int     hazir_kipi;   // 0 ready, 1 random, 2 stalled
    int     deger_hata;
    int     protokol_hata;
    int     teslim_sayisi;
    int     tahmin_teslim;

    // Reference state, updated on every rising edge
    logic                    calisti;
    getir_pkg::ps_t          beklenen_adres;
    getir_pkg::getir_cikis_t beklenen [$];
    getir_pkg::getir_cikis_t bas;
    logic                    bas_var;
    int                      ucusta;
    int                      bayat;
    int                      doluluk;

    logic           tbl_gecerli [getir_pkg::BTB_SATIR];
    getir_pkg::ps_t tbl_ps      [getir_pkg::BTB_SATIR];
    getir_pkg::ps_t tbl_hedef   [getir_pkg::BTB_SATIR];
    int             tbl_sayac   [getir_pkg::BTB_SATIR];

    logic yonlendirme;
    logic kabul;
    logic cikis;

    assign yonlendirme = ddb_yonlendirme.gecerli || yurut_yonlendirme.gecerli;
    assign kabul       = buyruk_istek_gecerli && buyruk_istek_hazir;
    assign cikis       = coz_gecerli && coz_hazir;

    getir dut_i (
        .clk_i                  ( clk_i ),
        .rst_n_i                ( rst_n_i ),
        .buyruk_istek_adres_o   ( buyruk_istek_adres ),
        .buyruk_istek_gecerli_o ( buyruk_istek_gecerli ),
        .buyruk_istek_hazir_i   ( buyruk_istek_hazir ),
        .buyruk_yanit_veri_i    ( buyruk_yanit_veri ),
        .buyruk_yanit_gecerli_i ( buyruk_yanit_gecerli ),
        .yurut_yonlendirme_i    ( yurut_yonlendirme ),
        .yurut_guncelleme_i     ( yurut_guncelleme ),
        .ddb_yonlendirme_i      ( ddb_yonlendirme ),
        .coz_cikis_o            ( coz_cikis ),
        .coz_gecerli_o          ( coz_gecerli ),
        .coz_hazir_i            ( coz_hazir )
    );

    tb_bellek_model #(
        .TOHUM        ( TOHUM ),
        .VERI_ANAHTAR ( VERI_ANAHTAR )
    ) bellek_i (
        .clk_i           ( clk_i ),
        .rst_n_i         ( rst_n_i ),
        .istek_adres_i   ( buyruk_istek_adres ),
        .istek_gecerli_i ( buyruk_istek_gecerli ),
        .istek_hazir_o   ( buyruk_istek_hazir ),
        .yanit_veri_o    ( buyruk_yanit_veri ),
        .yanit_gecerli_o ( buyruk_yanit_gecerli )
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    task automatic yanlis_deger(string ad, logic [31:0] beklenen_deger, logic [31:0] gercek);
        deger_hata++;
        $display("FAIL t=%0t %s expected=%h actual=%h", $time, ad, beklenen_deger, gercek);
    endtask

    task automatic kural_ihlali(string aciklama);
        protokol_hata++;
        $display("Error at t=%0t: %s", $time, aciklama);
    endtask

    // Taken when the entry holds this PC with a counter of 2 or more
    function automatic getir_pkg::tahmin_t tahmin_et(getir_pkg::ps_t ps);
        getir_pkg::tahmin_t t;
        t.hedef  = tbl_hedef[ps[5:2]];
        t.atladi = tbl_gecerli[ps[5:2]] && (tbl_ps[ps[5:2]] == ps) && (tbl_sayac[ps[5:2]] >= 2);
        return t;
    endfunction

    task automatic egit(getir_pkg::guncelleme_t g);
        int idx;
        idx = g.ps[5:2];
        if (tbl_gecerli[idx] && tbl_ps[idx] == g.ps) begin
            if (g.atladi && tbl_sayac[idx] < 3) begin
                tbl_sayac[idx]++;
            end else if (!g.atladi && tbl_sayac[idx] > 0) begin
                tbl_sayac[idx]--;
            end
        end else begin
            tbl_sayac[idx] = g.atladi ? 2 : 1;
        end
        tbl_gecerli[idx] = 1'b1;
        tbl_ps[idx]      = g.ps;
        tbl_hedef[idx]   = g.hedef;
    endtask

    always @(posedge clk_i) begin
        getir_pkg::tahmin_t      t;
        getir_pkg::getir_cikis_t giris;
        if (!rst_n_i) begin
            calisti        = 1'b0;
            beklenen_adres = getir_pkg::BASLANGIC_PS;
            beklenen.delete();
            ucusta = 0;
            bayat  = 0;
            for (int i = 0; i < getir_pkg::BTB_SATIR; i++) begin
                tbl_gecerli[i] = 1'b0;
            end
        end else begin
            calisti = 1'b1;
            // Stale responses come back before fresh ones
            if (buyruk_yanit_gecerli) begin
                ucusta--;
                if (bayat > 0) begin
                    bayat--;
                end
            end
            if (cikis) begin
                teslim_sayisi++;
                if (coz_cikis.atladi) begin
                    tahmin_teslim++;
                end
                if (beklenen.size() > 0) begin
                    void'(beklenen.pop_front());
                end
            end
            if (kabul) begin
                t            = tahmin_et(buyruk_istek_adres);
                giris.buyruk = buyruk_istek_adres ^ VERI_ANAHTAR;
                giris.ps     = buyruk_istek_adres;
                giris.atladi = t.atladi;
                beklenen.push_back(giris);
                ucusta++;
                beklenen_adres = t.atladi ? t.hedef : buyruk_istek_adres + 32'd4;
            end
            if (yonlendirme) begin
                beklenen_adres = ddb_yonlendirme.gecerli ? ddb_yonlendirme.ps
                                                         : yurut_yonlendirme.ps;
                beklenen.delete();
                bayat = ucusta;
            end
            if (yurut_guncelleme.gecerli) begin
                egit(yurut_guncelleme);
            end
        end
        doluluk = beklenen.size() + bayat;
        bas_var = beklenen.size() > 0;
        if (bas_var) begin
            bas = beklenen[0];
        end
    end

    ilk_bos: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !calisti |-> !buyruk_istek_gecerli && !coz_gecerli)
        else kural_ihlali("request or decode valid high in the first cycle after reset");

    adres_dogru: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        kabul |-> buyruk_istek_adres == beklenen_adres)
        else yanlis_deger("buyruk_istek_adres_o", $sampled(beklenen_adres),
                          $sampled(buyruk_istek_adres));

    yonlendirme_adresi: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        yonlendirme |=> buyruk_istek_adres == beklenen_adres)
        else yanlis_deger("buyruk_istek_adres_o", $sampled(beklenen_adres),
                          $sampled(buyruk_istek_adres));

    adres_sabit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        buyruk_istek_gecerli && !buyruk_istek_hazir
        |=> yonlendirme || (buyruk_istek_gecerli && $stable(buyruk_istek_adres)))
        else kural_ihlali("request dropped or address changed before acceptance");

    yonlendirmede_istek_yok: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        yonlendirme |-> !buyruk_istek_gecerli)
        else kural_ihlali("request valid high in a redirect cycle");

    istek_sinir: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        doluluk >= getir_pkg::KUYRUK_DERINLIK |-> !buyruk_istek_gecerli)
        else kural_ihlali("request issued with every queue slot in use");

    istek_surekli: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        calisti && !yonlendirme && doluluk < getir_pkg::KUYRUK_DERINLIK
        |-> buyruk_istek_gecerli)
        else kural_ihlali("no request although a queue slot is free");

    cikis_beklenen: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        cikis |-> bas_var)
        else kural_ihlali("decode took an instruction that was never fetched or was flushed");

    cikis_ps: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        cikis && bas_var |-> coz_cikis.ps == bas.ps)
        else yanlis_deger("coz_cikis_o.ps", $sampled(bas.ps), $sampled(coz_cikis.ps));

    cikis_buyruk: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        cikis && bas_var |-> coz_cikis.buyruk == bas.buyruk)
        else yanlis_deger("coz_cikis_o.buyruk", $sampled(bas.buyruk), $sampled(coz_cikis.buyruk));

    cikis_tahmin: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        cikis && bas_var |-> coz_cikis.atladi == bas.atladi)
        else yanlis_deger("coz_cikis_o.atladi", $sampled(bas.atladi), $sampled(coz_cikis.atladi));

    cikis_sabit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        coz_gecerli && !coz_hazir && !yonlendirme |=> coz_gecerli && $stable(coz_cikis))
        else kural_ihlali("decode payload changed or vanished while stalled");

    yonlendirme_sonrasi_bos: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        yonlendirme |=> !coz_gecerli)
        else kural_ihlali("decode valid high right after a redirect");

    // Advance to the next falling edge and clear single-cycle pulses
    task automatic cevrim_gec(int adet);
        repeat (adet) begin
            @(negedge clk_i);
            yurut_yonlendirme = '0;
            ddb_yonlendirme   = '0;
            yurut_guncelleme  = '0;
            case (hazir_kipi)
                0:       coz_hazir = 1'b1;
                1:       coz_hazir = ($random(seed) & 1) != 0;
                default: coz_hazir = 1'b0;
            endcase
        end
    endtask

    task automatic teslim_bekle(int adet);
        int hedef;
        hedef = teslim_sayisi + adet;
        while (teslim_sayisi < hedef) begin
            cevrim_gec(1);
        end
    endtask

    function automatic getir_pkg::ps_t rastgele_ps();
        return getir_pkg::BASLANGIC_PS + (getir_pkg::ps_t'($random(seed)) & 32'h0000_03fc);
    endfunction

    initial begin
        seed              = TOHUM;
        hazir_kipi        = 0;
        deger_hata        = 0;
        protokol_hata     = 0;
        teslim_sayisi     = 0;
        tahmin_teslim     = 0;
        rst_n_i           = 1'b0;
        yurut_yonlendirme = '0;
        yurut_guncelleme  = '0;
        ddb_yonlendirme   = '0;
        coz_hazir         = 1'b1;
        repeat (5) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;

        teslim_bekle(20);
        hazir_kipi = 1;
        teslim_bekle(30);

        // Long decode stall fills the queue
        hazir_kipi = 2;
        cevrim_gec(20);
        hazir_kipi = 0;
        teslim_bekle(8);

        // Train a taken branch, then steer fetch onto it
        cevrim_gec(1);
        yurut_guncelleme = '{ps: DALLANMA_PS, hedef: DALLANMA_HEDEF, atladi: 1'b1, gecerli: 1'b1};
        cevrim_gec(1);
        yurut_yonlendirme = '{ps: DALLANMA_PS, gecerli: 1'b1};
        teslim_bekle(10);

        hazir_kipi = 1;
        for (int i = 0; i < 20; i++) begin
            cevrim_gec(3 + ($random(seed) & 7));
            yurut_guncelleme = '{ps: rastgele_ps(), hedef: rastgele_ps(),
                                 atladi: ($random(seed) & 1) != 0, gecerli: 1'b1};
            yurut_yonlendirme = '{ps: rastgele_ps(), gecerli: 1'b1};
            if (i % 4 == 3) begin
                ddb_yonlendirme = '{ps: rastgele_ps() ^ 32'h0000_0400, gecerli: 1'b1};
            end
        end
        teslim_bekle(10);
        cevrim_gec(5);

        if (tahmin_teslim == 0) begin
            kural_ihlali("no instruction reached decode with a taken prediction");
        end
        $display("Errors: %0d value, %0d protocol, %0d total",
                 deger_hata, protokol_hata, deger_hata + protokol_hata);
        if (deger_hata + protokol_hata == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        repeat (ZAMAN_ASIMI) @(posedge clk_i);
        $display("Timeout: the run did not finish within %0d cycles", ZAMAN_ASIMI);
        $display("Errors: %0d value, %0d protocol, %0d total",
                 deger_hata, protokol_hata, deger_hata + protokol_hata);
        $display("Result: FAILED");
        $finish;
    end

endmodule
